/* design/crossbar.sv */
`default_nettype none
`timescale 1ns/1ns

`include "router_defs.svh"

module crossbar import router_pkg::*; (
	input wire logic clk,
	input wire logic reset_i,
	input wire flit_t [`NUM_PORTS-1:0] head_flit_i,
	input wire port_vec_t empty_i,
	input wire port_vec_t [`NUM_PORTS-1:0] grant_i, // [output][input].
	input wire port_vec_t out_ready_i,
	output port_vec_t rd_o,
	output flit_t [`NUM_PORTS-1:0] out_flit_o,
	output port_vec_t out_valid_o
);

	port_vec_t [`NUM_PORTS-1:0] rd_mat; // [output][input].
	port_vec_t [`NUM_PORTS-1:0] rd_col; // [input][output].
	flit_t [`NUM_PORTS-1:0] sel_flit;
	port_vec_t load;

	always_comb begin
		rd_o = '0;
		for (int o = 0; o < `NUM_PORTS; o++) begin
			sel_flit[o] = '0;
			for (int i = 0; i < `NUM_PORTS; i++) begin
				if (grant_i[o][i])
					sel_flit[o] = head_flit_i[i];
				rd_col[i][o] = grant_i[o][i] && !empty_i[i] &&
					(!out_valid_o[o] || out_ready_i[o]); // slot free or leaving.
				rd_mat[o][i] = rd_col[i][o];
			end
			load[o] = |rd_mat[o];
			rd_o = rd_o | rd_mat[o];
		end
	end

	always_ff @(posedge clk) begin
		for (int o = 0; o < `NUM_PORTS; o++) begin
			if (load[o])
				out_flit_o[o] <= sel_flit[o];
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			out_valid_o <= '0;
		end else begin
			for (int o = 0; o < `NUM_PORTS; o++) begin
				if (load[o])
					out_valid_o[o] <= 1'b1;
				else if (out_ready_i[o])
					out_valid_o[o] <= 1'b0; // taken downstream.
			end
		end
	end

	// two arbiters never own the same input.
	for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_rd_chk
		a_single_reader: assert property (@(posedge clk) disable iff (reset_i)
			$onehot0(rd_col[i]));
	end

endmodule

`default_nettype wire

/* design/input_buffer.sv */
`default_nettype none
`timescale 1ns/1ns

`include "router_defs.svh"

module input_buffer import router_pkg::*; #(
	parameter int DEPTH = `BUFFER_DEPTH
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire flit_t wr_flit_i,
	input wire logic wr_valid_i,
	input wire logic rd_i,
	output logic wr_ready_o,
	output flit_t head_flit_o,
	output logic empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	flit_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic wr_en;
	logic rd_en;

	assign wr_ready_o = (count_q != CNT_W'(DEPTH));
	assign empty_o = (count_q == '0);
	assign head_flit_o = mem[rd_ptr_q];

	assign wr_en = wr_valid_i && wr_ready_o; // valid/ready handshake.
	assign rd_en = rd_i && !empty_o; // pop strobe from crossbar.

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr_q] <= wr_flit_i;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (wr_en)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (rd_en)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q; // both or neither.
			endcase
		end
	end

	// the crossbar only strobes a buffer that has a flit.
	a_no_read_empty: assert property (@(posedge clk) disable iff (reset_i)
		rd_i |-> !empty_o);

	// a full buffer that is not drained takes nothing new.
	a_no_write_full: assert property (@(posedge clk) disable iff (reset_i)
		(count_q == CNT_W'(DEPTH)) && !rd_i |=> (count_q == CNT_W'(DEPTH)));

endmodule

`default_nettype wire

/* design/noc_router.sv */
`default_nettype none
`timescale 1ns/1ns

`include "router_defs.svh"

module noc_router import router_pkg::*; (
	input wire logic clk,
	input wire logic reset_i,
	input wire node_addr_t router_addr_i,
	input wire flit_t [`NUM_PORTS-1:0] in_flit_i,
	input wire port_vec_t in_valid_i,
	input wire port_vec_t out_ready_i,
	output port_vec_t in_ready_o,
	output flit_t [`NUM_PORTS-1:0] out_flit_o,
	output port_vec_t out_valid_o
);

	flit_t [`NUM_PORTS-1:0] head_flit;
	port_vec_t empty;
	port_vec_t rd;
	port_vec_t last;
	port_vec_t [`NUM_PORTS-1:0] req; // [input][output].
	port_vec_t [`NUM_PORTS-1:0] arb_req; // [output][input].
	port_vec_t [`NUM_PORTS-1:0] grant; // [output][input].

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per port buffer, route stage and arbiter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
		input_buffer #(
			.DEPTH(`BUFFER_DEPTH)
		) i_input_buffer (
			.clk(clk),
			.reset_i(reset_i),
			.wr_flit_i(in_flit_i[p]),
			.wr_valid_i(in_valid_i[p]),
			.rd_i(rd[p]),
			.wr_ready_o(in_ready_o[p]),
			.head_flit_o(head_flit[p]),
			.empty_o(empty[p])
		);

		route_compute #(
			.IN_PORT(port_idx_t'(p))
		) i_route_compute (
			.clk(clk),
			.reset_i(reset_i),
			.router_addr_i(router_addr_i),
			.head_flit_i(head_flit[p]),
			.empty_i(empty[p]),
			.rd_i(rd[p]),
			.req_o(req[p]),
			.last_o(last[p])
		);

		// arbiter p sees bit p of every input's request.
		for (genvar q = 0; q < `NUM_PORTS; q++) begin : g_xpose
			assign arb_req[p][q] = req[q][p];
		end

		output_arbiter i_output_arbiter (
			.clk(clk),
			.reset_i(reset_i),
			.req_i(arb_req[p]),
			.last_i(last),
			.rd_i(rd),
			.grant_o(grant[p])
		);
	end

	crossbar i_crossbar (
		.clk(clk),
		.reset_i(reset_i),
		.head_flit_i(head_flit),
		.empty_i(empty),
		.grant_i(grant),
		.out_ready_i(out_ready_i),
		.rd_o(rd),
		.out_flit_o(out_flit_o),
		.out_valid_o(out_valid_o)
	);

endmodule

`default_nettype wire

/* design/output_arbiter.sv */
`default_nettype none
`timescale 1ns/1ns

`include "router_defs.svh"

module output_arbiter import router_pkg::*; (
	input wire logic clk,
	input wire logic reset_i,
	input wire port_vec_t req_i,
	input wire port_vec_t last_i,
	input wire port_vec_t rd_i,
	output port_vec_t grant_o
);

	port_idx_t ptr_q;
	port_vec_t pick;
	logic release_grant;
	int served_idx;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// rotating priority pick
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		int idx;
		pick = '0;
		// walk down so the port nearest the pointer wins.
		for (int k = `NUM_PORTS - 1; k >= 0; k--) begin
			idx = (int'(ptr_q) + k) % `NUM_PORTS;
			if (req_i[idx])
				pick = port_vec_t'(1) << idx;
		end
	end

	always_comb begin
		served_idx = 0;
		for (int i = 0; i < `NUM_PORTS; i++) begin
			if (grant_o[i])
				served_idx = i;
		end
	end

	// last flit of the packet leaves the granted input.
	assign release_grant = |(grant_o & rd_i & last_i);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			grant_o <= '0;
			ptr_q <= PORT_N;
		end else if (grant_o == '0) begin
			grant_o <= pick; // zero if nobody asks.
		end else if (release_grant) begin
			grant_o <= '0;
			if (served_idx == `NUM_PORTS - 1)
				ptr_q <= PORT_N;
			else
				ptr_q <= port_idx_t'(served_idx + 1);
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
		$onehot0(grant_o));

endmodule

`default_nettype wire

/* design/route_compute.sv */
`default_nettype none
`timescale 1ns/1ns

`include "router_defs.svh"

module route_compute import router_pkg::*; #(
	parameter port_idx_t IN_PORT = PORT_N
) (
	input wire logic clk,
	input wire logic reset_i,
	input wire node_addr_t router_addr_i,
	input wire flit_t head_flit_i,
	input wire logic empty_i,
	input wire logic rd_i,
	output port_vec_t req_o,
	output logic last_o
);

	node_addr_t dest_addr;
	coord_t dest_y;
	coord_t dest_x;
	coord_t router_y;
	coord_t router_x;
	port_idx_t route_now;
	port_idx_t route_q;
	port_idx_t route_cur;
	route_state_t state_q;
	flit_cnt_t cnt_q;

	assign dest_addr = head_flit_i[`ADDR_WIDTH-1:0];
	assign dest_y = dest_addr[`ADDR_WIDTH-1:`COORD_WIDTH];
	assign dest_x = dest_addr[`COORD_WIDTH-1:0];
	assign router_y = router_addr_i[`ADDR_WIDTH-1:`COORD_WIDTH];
	assign router_x = router_addr_i[`COORD_WIDTH-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// yx dimension order, y resolved first
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		if (dest_y < router_y)
			route_now = PORT_N;
		else if (dest_y > router_y)
			route_now = PORT_S;
		else if (dest_x < router_x)
			route_now = PORT_W;
		else if (dest_x > router_x)
			route_now = PORT_E;
		else
			route_now = PORT_L;
	end

	assign route_cur = (state_q == ROUTE_HEAD) ? route_now : route_q; // body uses held port.
	assign req_o = empty_i ? '0 : (port_vec_t'(1) << route_cur);
	assign last_o = (cnt_q == flit_cnt_t'(`PACKET_FLITS - 1));

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= ROUTE_HEAD;
			route_q <= PORT_N;
			cnt_q <= '0;
		end else if (rd_i) begin
			case (state_q)
				ROUTE_HEAD: begin
					route_q <= route_now; // latch port at header read.
					state_q <= ROUTE_BODY;
					cnt_q <= cnt_q + 1'b1;
				end
				ROUTE_BODY: begin
					if (last_o) begin
						state_q <= ROUTE_HEAD;
						cnt_q <= '0;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				default: state_q <= ROUTE_HEAD;
			endcase
		end
	end

	// no u-turn, the header never names the port it came in on.
	a_no_uturn: assert property (@(posedge clk) disable iff (reset_i)
		!req_o[IN_PORT]);

endmodule

`default_nettype wire

/* design/router_defs.svh */
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flit and address layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FLIT_WIDTH 16 // header carries dest in the low byte.
`define ADDR_WIDTH 8 // y in high nibble, x in low nibble.
`define COORD_WIDTH 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// router sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NUM_PORTS 5 // n, s, w, e, l.
`define PACKET_FLITS 4 // header included.
`define BUFFER_DEPTH 4

`endif

/* design/router_pkg.sv */
`default_nettype none

`include "router_defs.svh"

package router_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// payload and address vectors
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [`FLIT_WIDTH-1:0] flit_t;
	typedef logic [`ADDR_WIDTH-1:0] node_addr_t; // {y, x}.
	typedef logic [`COORD_WIDTH-1:0] coord_t;

	// one bit per port, bit 0 is north.
	typedef logic [`NUM_PORTS-1:0] port_vec_t;

	typedef enum logic [2:0] {
		PORT_N = 3'd0,
		PORT_S = 3'd1,
		PORT_W = 3'd2,
		PORT_E = 3'd3,
		PORT_L = 3'd4
	} port_idx_t;

	// position of the head flit inside its packet.
	typedef logic [$clog2(`PACKET_FLITS)-1:0] flit_cnt_t;

	typedef enum logic {
		ROUTE_HEAD,
		ROUTE_BODY
	} route_state_t;

endpackage

`default_nettype wire

/* noc_router.f */
+incdir+design
design/router_pkg.sv
design/input_buffer.sv
design/route_compute.sv
design/output_arbiter.sv
design/crossbar.sv
design/noc_router.sv
verification/noc_router_tb.sv

/* run.sh */
#!/bin/sh
# compile the router testbench with verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

TOP=noc_router_tb
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f noc_router.f --top-module "$TOP" -o "$TOP"

./obj_dir/"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF '*** PASSED ***' "$LOG"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* verification/noc_router_tb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "router_defs.svh"

module noc_router_tb import router_pkg::*; ();

	localparam int NP = `NUM_PORTS;
	localparam int PF = `PACKET_FLITS;
	localparam int CLK_PERIOD = 8;
	localparam int NUM_TESTS = 5;
	localparam int STREAM_PKTS = 6; // per input in the random phase.
	localparam int TOTAL_PACKETS = 1 + 20 + 3 + 2 + STREAM_PKTS * NP;
	localparam int WATCHDOG_CYCLES = 20 * TOTAL_PACKETS * PF * NUM_TESTS;
	localparam node_addr_t ROUTER_ADDR = 8'h22;

	logic clk = 1'b0;
	logic reset_i = 1'b1;
	flit_t [NP-1:0] in_flit_i = '0;
	port_vec_t in_valid_i = '0;
	port_vec_t out_ready_i = '1;
	port_vec_t in_ready_o;
	flit_t [NP-1:0] out_flit_o;
	port_vec_t out_valid_o;

	node_addr_t dests [NP] = '{8'h10, 8'h35, 8'h21, 8'h2a, 8'h22}; // n, s, w, e, l.
	flit_t src_q [NP][$]; // flits still to enter each input.
	flit_t exp_q [NP*NP][$]; // [output*NP+input].
	int east_order [$];
	int seq_num [NP];
	int pkt_src [NP];
	int pkt_cnt [NP];
	int pending = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	integer seed = 32'hb2b1;

	always #(CLK_PERIOD / 2) clk = ~clk;

	noc_router i_noc_router (
		.clk(clk),
		.reset_i(reset_i),
		.router_addr_i(ROUTER_ADDR),
		.in_flit_i(in_flit_i),
		.in_valid_i(in_valid_i),
		.out_ready_i(out_ready_i),
		.in_ready_o(in_ready_o),
		.out_flit_o(out_flit_o),
		.out_valid_o(out_valid_o)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model and scoreboard
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic int expected_port(node_addr_t dest);
		if (dest[7:4] != ROUTER_ADDR[7:4]) // rows first.
			return (dest[7:4] < ROUTER_ADDR[7:4]) ? PORT_N : PORT_S;
		if (dest[3:0] != ROUTER_ADDR[3:0])
			return (dest[3:0] < ROUTER_ADDR[3:0]) ? PORT_W : PORT_E;
		return PORT_L;
	endfunction

	// flit is {source, index, sequence, dest or payload byte}.
	function automatic void queue_packet(int src, node_addr_t dest);
		int exit_port;
		flit_t f;
		exit_port = expected_port(dest);
		for (int k = 0; k < PF; k++) begin
			f = {src[2:0], k[1:0], seq_num[src][2:0],
				(k == 0) ? dest : 8'((seq_num[src] << 2) | k)};
			src_q[src].push_back(f);
			exp_q[exit_port * NP + src].push_back(f);
		end
		seq_num[src]++;
		pending += PF;
	endfunction

	function automatic void check_output(int o, flit_t f);
		int s;
		logic known;
		flit_t want;
		s = int'(f[15:13]);
		known = (s < NP) ? (exp_q[o * NP + s].size() != 0) : 1'b0;
		pending--;
		assert (known) else begin
			$display("output %0d delivered flit %h that no input sent there", o, f);
			errors++;
		end
		if (known) begin
			want = exp_q[o * NP + s].pop_front();
			assert (f == want) else begin
				$display("Mismatch out_flit_o[%0d]: got %h, expected %h", o, f, want);
				errors++;
			end
			if (pkt_cnt[o] == 0) begin
				pkt_src[o] = s; // header opens a packet.
				if (o == PORT_E)
					east_order.push_back(s);
			end
			assert (s == pkt_src[o]) else begin
				$display("output %0d mixed input %0d into a packet of input %0d",
					o, s, pkt_src[o]);
				errors++;
			end
			pkt_cnt[o] = (pkt_cnt[o] + 1) % PF;
		end
	endfunction

	// sources and sink run on the rising edge.
	always @(posedge clk) begin
		if (reset_i) begin
			in_valid_i <= '0;
		end else begin
			for (int p = 0; p < NP; p++) begin
				if (in_valid_i[p] && in_ready_o[p])
					void'(src_q[p].pop_front()); // taken on this edge.
				in_valid_i[p] <= (src_q[p].size() != 0);
				if (src_q[p].size() != 0)
					in_flit_i[p] <= src_q[p][0];
				if (out_valid_o[p] && out_ready_i[p])
					check_output(p, out_flit_o[p]);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apply_reset();
		@(posedge clk);
		reset_i <= 1'b1;
		repeat (16) @(posedge clk);
		reset_i <= 1'b0;
	endtask

	task automatic wait_drain(int limit);
		int n;
		n = 0;
		@(negedge clk);
		while ((pending > 0) && (n < limit)) begin
			@(negedge clk);
			n++;
		end
		assert (pending == 0) else begin
			$display("%0d flits did not arrive within %0d cycles", pending, limit);
			errors++;
		end
		for (int i = 0; i < NP * NP; i++) begin
			assert (exp_q[i].size() == 0) else begin
				$display("output %0d never got %0d flits of input %0d",
					i / NP, exp_q[i].size(), i % NP);
				errors++;
			end
		end
	endtask

	task automatic finish_test(string name, int err_start);
		tests_run++;
		if (errors != err_start)
			tests_failed++;
		$display("test %-16s %0d errors", name, errors - err_start);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic reset_state_test();
		int err_start;
		err_start = errors;
		@(negedge clk);
		assert (out_valid_o == '0) else begin
			$display("Mismatch out_valid_o: got %h, expected 00", out_valid_o);
			errors++;
		end
		assert (in_ready_o == '1) else begin
			$display("Mismatch in_ready_o: got %h, expected 1f", in_ready_o);
			errors++;
		end
		finish_test("reset_state", err_start);
	endtask

	task automatic single_packet_test();
		int err_start;
		err_start = errors;
		@(negedge clk);
		queue_packet(PORT_L, 8'h25);
		wait_drain(50);
		finish_test("single_packet", err_start);
	endtask

	task automatic yx_routing_test();
		int err_start;
		err_start = errors;
		@(negedge clk);
		for (int s = 0; s < NP; s++)
			for (int d = 0; d < NP; d++)
				if (expected_port(dests[d]) != s)
					queue_packet(s, dests[d]);
		wait_drain(400);
		finish_test("yx_routing", err_start);
	endtask

	task automatic round_robin_test();
		int err_start;
		int n;
		flit_t north_head;
		err_start = errors;
		east_order.delete();
		@(posedge clk);
		out_ready_i[PORT_E] <= 1'b0;
		@(negedge clk);
		queue_packet(PORT_N, 8'h25);
		queue_packet(PORT_S, 8'h25);
		queue_packet(PORT_W, 8'h25);
		north_head = exp_q[PORT_E * NP + PORT_N][0];
		n = 0;
		while ((src_q[PORT_N].size() + src_q[PORT_S].size() + src_q[PORT_W].size() > 0) &&
			(n < 50)) begin
			@(negedge clk);
			n++;
		end
		// the output register holds the first granted header.
		assert (out_valid_o[PORT_E]) else begin
			$display("east held no flit in its output register while its ready was low");
			errors++;
		end
		assert (out_flit_o[PORT_E] == north_head) else begin
			$display("Mismatch out_flit_o[%0d]: got %h, expected %h", PORT_E,
				out_flit_o[PORT_E], north_head);
			errors++;
		end
		@(posedge clk);
		out_ready_i[PORT_E] <= 1'b1;
		wait_drain(100);
		assert ((east_order.size() == 3) && (east_order[0] == PORT_N) &&
			(east_order[1] == PORT_S) && (east_order[2] == PORT_W)) else begin
			$display("east did not serve north, south and west in that order");
			errors++;
		end
		finish_test("round_robin", err_start);
	endtask

	task automatic back_pressure_test();
		int err_start;
		int n;
		int idx;
		logic fell;
		err_start = errors;
		@(posedge clk);
		out_ready_i[PORT_W] <= 1'b0;
		@(negedge clk);
		queue_packet(PORT_E, 8'h21);
		queue_packet(PORT_E, 8'h21);
		fell = 1'b0;
		n = 0;
		while (!fell && (n < 40)) begin
			@(negedge clk);
			fell = !in_ready_o[PORT_E];
			n++;
		end
		assert (fell) else begin
			$display("east input kept in_ready_o high while west was held");
			errors++;
		end
		@(posedge clk);
		out_ready_i[PORT_W] <= 1'b1;
		wait_drain(100);
		assert (in_ready_o == '1) else begin
			$display("Mismatch in_ready_o: got %h, expected 1f", in_ready_o);
			errors++;
		end
		for (int s = 0; s < NP; s++) begin
			for (int k = 0; k < STREAM_PKTS; k++) begin
				idx = int'($unsigned($random(seed)) % NP);
				if (expected_port(dests[idx]) == s)
					idx = (idx + 1) % NP; // no u-turn.
				queue_packet(s, dests[idx]);
			end
		end
		n = 0;
		while ((pending > 0) && (n < 3000)) begin
			@(posedge clk);
			out_ready_i <= port_vec_t'($random(seed));
			n++;
			@(negedge clk);
		end
		@(posedge clk);
		out_ready_i <= '1;
		wait_drain(100);
		finish_test("back_pressure", err_start);
	endtask

	initial begin
		apply_reset();
		reset_state_test();
		single_packet_test();
		yx_routing_test();
		apply_reset(); // round-robin pointers back at north.
		round_robin_test();
		back_pressure_test();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if ((errors == 0) && (tests_run == NUM_TESTS))
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
